//--- src/ro_mem_pkg.sv
package ro_mem_pkg;

   // cache line geometry, 4-byte words only
   localparam int LINE_WORDS = 16;
   localparam int LINE_BITS  = 512;
   localparam int WORD_BITS  = LINE_BITS / LINE_WORDS;
   localparam int ADDR_W     = 32;
   localparam int TAG_W      = 8;   // free list hands out the low bits

   typedef logic [LINE_WORDS-1:0] word_mask_t;  // one bit per word of a line

   typedef logic [TAG_W-1:0] mem_tag_t;

   // read address channel
   typedef struct packed {
      logic [ADDR_W-1:0] addr;   // byte address, word aligned
      mem_tag_t          tag;
   } ar_req_t;

   // read data channel, one full line per beat
   typedef struct packed {
      mem_tag_t             tag;
      logic [LINE_BITS-1:0] data;
   } r_beat_t;

endpackage

//--- src/ro_task_pkg.sv
package ro_task_pkg;

   typedef logic [31:0] task_t;       // opaque to this stage
   typedef logic [5:0]  burst_len_t;  // 1..32 words
   typedef logic [4:0]  word_idx_t;
   typedef logic [2:0]  thread_id_t;  // up to 8 threads

   typedef struct packed {
      task_t                           tsk;
      logic [ro_mem_pkg::ADDR_W-1:0]   addr;
      burst_len_t                      len;
   } task_req_t;

   // one outstanding line read
   typedef struct packed {
      thread_id_t              thread;
      ro_mem_pkg::word_mask_t  mask;
      word_idx_t               start_idx;  // task index of the first masked word
      logic                    last_line;
   } mshr_entry_t;

   typedef struct packed {
      task_t      tsk;
      logic [31:0] data;
      word_idx_t  idx;
      logic       last;
   } out_beat_t;

   typedef enum logic {SPLIT_IDLE, SPLIT_ISSUE} split_state_t;

   typedef enum logic {UNPACK_IDLE, UNPACK_EMIT} unpack_state_t;

endpackage

//--- src/free_list.sv
`timescale 1ns/1ps

module free_list #(
   parameter int LOG_DEPTH = 2,
   parameter int ID_W      = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 push,
   input  logic [ID_W-1:0]      push_id,
   input  logic                 pop,
   output logic [ID_W-1:0]      head_id,
   output logic                 empty,
   output logic                 full,
   output logic [LOG_DEPTH:0]   count
);

   localparam int DEPTH = 2 ** LOG_DEPTH;

   logic [ID_W-1:0]      ids [DEPTH];
   logic [LOG_DEPTH-1:0] rd_ptr;
   logic [LOG_DEPTH-1:0] wr_ptr;

   // list starts out holding every id, in order
   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < DEPTH; i++) begin
            ids[i] <= ID_W'(i);
         end
      end else if (push) begin
         ids[wr_ptr] <= push_id;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= (LOG_DEPTH+1)'(DEPTH);
      end else begin
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         if (push) wr_ptr <= wr_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   assign head_id = ids[rd_ptr];
   assign empty   = (count == '0);
   assign full    = (count == (LOG_DEPTH+1)'(DEPTH));  // every id returned

endmodule

//--- src/req_intake.sv
`timescale 1ns/1ps

module req_intake #(
   parameter int N_THREADS = 4
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     req_valid,
   output logic                     req_ready,
   input  ro_task_pkg::task_req_t   req,
   output logic                     start_valid,
   input  logic                     start_ready,
   output ro_task_pkg::thread_id_t  start_thread,
   output logic [31:0]              start_addr,
   output ro_task_pkg::burst_len_t  start_len,
   input  ro_task_pkg::thread_id_t  ctx_thread,
   output ro_task_pkg::task_t       ctx_task,
   input  logic                     thread_release,
   input  ro_task_pkg::thread_id_t  release_thread,
   output logic                     idle
);

   localparam int TW = $clog2(N_THREADS);

   ro_task_pkg::task_t      ctx_mem [N_THREADS];
   ro_task_pkg::thread_id_t thr_head;
   logic                    thr_empty;
   logic                    accept;

   free_list #(
      .LOG_DEPTH (TW),
      .ID_W      ($bits(ro_task_pkg::thread_id_t))
   ) i_thread_free_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (thread_release),
      .push_id (release_thread),
      .pop     (accept),
      .head_id (thr_head),
      .empty   (thr_empty),
      .full    (idle),     // all threads home
      .count   ()
   );

   // accept and handoff to the splitter are the same cycle
   assign start_valid  = req_valid & !thr_empty;
   assign req_ready    = !thr_empty & start_ready;
   assign accept       = req_valid & req_ready;
   assign start_thread = thr_head;
   assign start_addr   = req.addr;
   assign start_len    = req.len;

   always_ff @(posedge clk) begin
      if (accept) ctx_mem[thr_head[TW-1:0]] <= req.tsk;
   end

   assign ctx_task = ctx_mem[ctx_thread[TW-1:0]];

endmodule

//--- src/line_splitter.sv
`timescale 1ns/1ps

module line_splitter #(
   parameter int LOG_N_TAGS = 3
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      start_valid,
   output logic                      start_ready,
   input  ro_task_pkg::thread_id_t   start_thread,
   input  logic [31:0]               start_addr,
   input  ro_task_pkg::burst_len_t   start_len,
   output logic                      arvalid,
   input  logic                      arready,
   output ro_mem_pkg::ar_req_t       ar,
   output logic                      mshr_wr,
   output logic [LOG_N_TAGS-1:0]     mshr_wr_tag,
   output ro_task_pkg::mshr_entry_t  mshr_wr_entry,
   input  logic                      tag_free_valid,
   input  logic [LOG_N_TAGS-1:0]     tag_free
);

   ro_task_pkg::split_state_t state;
   logic [31:0]               cur_addr;
   ro_task_pkg::burst_len_t   rem_words;
   ro_task_pkg::word_idx_t    issued;
   ro_task_pkg::thread_id_t   cur_thread;

   logic [3:0]              off;
   logic [5:0]              room;
   logic [5:0]              take;
   logic                    last_line;
   ro_mem_pkg::word_mask_t  mask;
   logic [LOG_N_TAGS-1:0]   tag_head;
   logic                    tag_empty;
   logic                    ar_fire;

   free_list #(
      .LOG_DEPTH (LOG_N_TAGS),
      .ID_W      (LOG_N_TAGS)
   ) i_tag_free_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (tag_free_valid),
      .push_id (tag_free),
      .pop     (ar_fire),
      .head_id (tag_head),
      .empty   (tag_empty),
      .full    (),
      .count   ()
   );

   // words left in the current line vs. words left in the burst
   always_comb begin
      off       = cur_addr[5:2];
      room      = 6'(ro_mem_pkg::LINE_WORDS) - {2'b00, off};
      take      = (rem_words < room) ? rem_words : room;
      last_line = (rem_words <= room);
      for (int i = 0; i < ro_mem_pkg::LINE_WORDS; i++) begin
         mask[i] = (i >= int'(off)) && (i < int'(off) + int'(take));
      end
   end

   assign arvalid     = (state == ro_task_pkg::SPLIT_ISSUE) & !tag_empty;
   assign ar_fire     = arvalid & arready;
   assign start_ready = (state == ro_task_pkg::SPLIT_IDLE) | (ar_fire & last_line);

   always_comb begin
      ar.addr                  = cur_addr;
      ar.tag                   = '0;
      ar.tag[LOG_N_TAGS-1:0]   = tag_head;
      mshr_wr_entry.thread     = cur_thread;
      mshr_wr_entry.mask       = mask;
      mshr_wr_entry.start_idx  = issued;
      mshr_wr_entry.last_line  = last_line;
   end

   assign mshr_wr     = ar_fire;
   assign mshr_wr_tag = tag_head;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ro_task_pkg::SPLIT_IDLE;
      end else if (start_valid & start_ready) begin
         state <= ro_task_pkg::SPLIT_ISSUE;
      end else if (ar_fire & last_line) begin
         state <= ro_task_pkg::SPLIT_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (start_valid & start_ready) begin
         cur_addr   <= start_addr;
         rem_words  <= start_len;
         issued     <= '0;
         cur_thread <= start_thread;
      end else if (ar_fire) begin
         cur_addr  <= cur_addr + {24'd0, take, 2'b00};  // next line boundary
         rem_words <= rem_words - take;
         issued    <= issued + take[4:0];
      end
   end

endmodule

//--- src/mshr_table.sv
`timescale 1ns/1ps

module mshr_table #(
   parameter int LOG_N_TAGS = 3
) (
   input  logic                      clk,
   input  logic                      wr,
   input  logic [LOG_N_TAGS-1:0]     wr_tag,
   input  ro_task_pkg::mshr_entry_t  wr_entry,
   input  logic [LOG_N_TAGS-1:0]     rd_tag,
   output ro_task_pkg::mshr_entry_t  rd_entry
);

   ro_task_pkg::mshr_entry_t entries [2**LOG_N_TAGS];

   // filled at issue time
   always_ff @(posedge clk) begin
      if (wr) entries[wr_tag] <= wr_entry;
   end

   // looked up in the response cycle
   assign rd_entry = entries[rd_tag];

endmodule

//--- src/word_unpacker.sv
`timescale 1ns/1ps

module word_unpacker #(
   parameter int LOG_N_TAGS = 3
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      rvalid,
   output logic                      rready,
   input  ro_mem_pkg::r_beat_t       r,
   output logic [LOG_N_TAGS-1:0]     mshr_rd_tag,
   input  ro_task_pkg::mshr_entry_t  mshr_rd_entry,
   output logic                      tag_free_valid,
   output logic [LOG_N_TAGS-1:0]     tag_free,
   output ro_task_pkg::thread_id_t   ctx_thread,
   input  ro_task_pkg::task_t        ctx_task,
   output logic                      out_valid,
   input  logic                      out_ready,
   output ro_task_pkg::out_beat_t    out,
   output logic                      thread_release,
   output ro_task_pkg::thread_id_t   release_thread
);

   ro_task_pkg::unpack_state_t       state;
   logic [ro_mem_pkg::LINE_BITS-1:0] data_q;
   ro_mem_pkg::word_mask_t           mask_q;
   ro_mem_pkg::word_mask_t           mask_next;
   ro_task_pkg::word_idx_t           widx_q;
   ro_task_pkg::thread_id_t          thread_q;
   logic                             last_line_q;
   logic [3:0]                       pos;
   logic                             r_fire;
   logic                             out_fire;
   logic                             final_word;

   assign r_fire      = rvalid & rready;
   assign mshr_rd_tag = r.tag[LOG_N_TAGS-1:0];

   // tag is free again once its entry has been captured
   assign tag_free_valid = r_fire;
   assign tag_free       = r.tag[LOG_N_TAGS-1:0];

   // lowest pending word
   always_comb begin
      pos = '0;
      for (int i = ro_mem_pkg::LINE_WORDS - 1; i >= 0; i--) begin
         if (mask_q[i]) pos = 4'(i);
      end
   end

   assign mask_next  = mask_q & (mask_q - 1'b1);
   assign out_valid  = (state == ro_task_pkg::UNPACK_EMIT);
   assign out_fire   = out_valid & out_ready;
   assign final_word = out_fire & (mask_next == '0);
   assign rready     = (state == ro_task_pkg::UNPACK_IDLE) | final_word;

   assign ctx_thread = thread_q;

   always_comb begin
      out.tsk  = ctx_task;
      out.data = data_q[pos*ro_mem_pkg::WORD_BITS +: ro_mem_pkg::WORD_BITS];
      out.idx  = widx_q;
      out.last = last_line_q & (mask_next == '0);  // single bit left in the final line
   end

   assign thread_release = out_fire & out.last;
   assign release_thread = thread_q;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ro_task_pkg::UNPACK_IDLE;
      end else if (r_fire) begin
         state <= ro_task_pkg::UNPACK_EMIT;
      end else if (final_word) begin
         state <= ro_task_pkg::UNPACK_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         data_q      <= r.data;
         mask_q      <= mshr_rd_entry.mask;
         widx_q      <= mshr_rd_entry.start_idx;
         thread_q    <= mshr_rd_entry.thread;
         last_line_q <= mshr_rd_entry.last_line;
      end else if (out_fire) begin
         mask_q <= mask_next;
         widx_q <= widx_q + 5'd1;
      end
   end

endmodule

//--- src/ro_stage_top.sv
`timescale 1ns/1ps

module ro_stage_top #(
   parameter int N_THREADS  = 4,
   parameter int LOG_N_TAGS = 3
) (
   input  logic                    clk,
   input  logic                    rstn,
   input  logic                    req_valid,
   output logic                    req_ready,
   input  ro_task_pkg::task_req_t  req,
   output logic                    arvalid,
   input  logic                    arready,
   output ro_mem_pkg::ar_req_t     ar,
   input  logic                    rvalid,
   output logic                    rready,
   input  ro_mem_pkg::r_beat_t     r,
   output logic                    out_valid,
   input  logic                    out_ready,
   output ro_task_pkg::out_beat_t  out,
   output logic                    idle
);

   logic                      start_valid;
   logic                      start_ready;
   ro_task_pkg::thread_id_t   start_thread;
   logic [31:0]               start_addr;
   ro_task_pkg::burst_len_t   start_len;
   logic                      mshr_wr;
   logic [LOG_N_TAGS-1:0]     mshr_wr_tag;
   ro_task_pkg::mshr_entry_t  mshr_wr_entry;
   logic [LOG_N_TAGS-1:0]     mshr_rd_tag;
   ro_task_pkg::mshr_entry_t  mshr_rd_entry;
   logic                      tag_free_valid;
   logic [LOG_N_TAGS-1:0]     tag_free;
   ro_task_pkg::thread_id_t   ctx_thread;
   ro_task_pkg::task_t        ctx_task;
   logic                      thread_release;
   ro_task_pkg::thread_id_t   release_thread;

   req_intake #(.N_THREADS(N_THREADS)) i_req_intake (
      .clk            (clk),
      .rstn           (rstn),
      .req_valid      (req_valid),
      .req_ready      (req_ready),
      .req            (req),
      .start_valid    (start_valid),
      .start_ready    (start_ready),
      .start_thread   (start_thread),
      .start_addr     (start_addr),
      .start_len      (start_len),
      .ctx_thread     (ctx_thread),
      .ctx_task       (ctx_task),
      .thread_release (thread_release),
      .release_thread (release_thread),
      .idle           (idle)
   );

   line_splitter #(.LOG_N_TAGS(LOG_N_TAGS)) i_line_splitter (
      .clk            (clk),
      .rstn           (rstn),
      .start_valid    (start_valid),
      .start_ready    (start_ready),
      .start_thread   (start_thread),
      .start_addr     (start_addr),
      .start_len      (start_len),
      .arvalid        (arvalid),
      .arready        (arready),
      .ar             (ar),
      .mshr_wr        (mshr_wr),
      .mshr_wr_tag    (mshr_wr_tag),
      .mshr_wr_entry  (mshr_wr_entry),
      .tag_free_valid (tag_free_valid),
      .tag_free       (tag_free)
   );

   mshr_table #(.LOG_N_TAGS(LOG_N_TAGS)) i_mshr_table (
      .clk      (clk),
      .wr       (mshr_wr),
      .wr_tag   (mshr_wr_tag),
      .wr_entry (mshr_wr_entry),
      .rd_tag   (mshr_rd_tag),
      .rd_entry (mshr_rd_entry)
   );

   word_unpacker #(.LOG_N_TAGS(LOG_N_TAGS)) i_word_unpacker (
      .clk            (clk),
      .rstn           (rstn),
      .rvalid         (rvalid),
      .rready         (rready),
      .r              (r),
      .mshr_rd_tag    (mshr_rd_tag),
      .mshr_rd_entry  (mshr_rd_entry),
      .tag_free_valid (tag_free_valid),
      .tag_free       (tag_free),
      .ctx_thread     (ctx_thread),
      .ctx_task       (ctx_task),
      .out_valid      (out_valid),
      .out_ready      (out_ready),
      .out            (out),
      .thread_release (thread_release),
      .release_thread (release_thread)
   );

endmodule

//--- tests/tb_funcs.svh
// data word that the memory holds at a byte address
function automatic logic [31:0] ref_word(input logic [31:0] addr);
   return (addr * 32'h9e37_79b1) ^ {addr[7:0], addr[31:8]};
endfunction

// one step of a 32-bit LCG
function automatic logic [31:0] lcg_step(input logic [31:0] s);
   return s * 32'd1664525 + 32'd1013904223;
endfunction

//--- tests/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
   parameter logic [31:0] SEED = 32'd88
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 arvalid,
   output logic                 arready,
   input  ro_mem_pkg::ar_req_t  ar,
   output logic                 rvalid,
   input  logic                 rready,
   output ro_mem_pkg::r_beat_t  r
);

   `include "tb_funcs.svh"

   logic [31:0]          rng;
   logic [31:0]          addr_q [$];
   ro_mem_pkg::mem_tag_t tag_q [$];
   int                   due_q [$];
   int                   cycle;

   function automatic logic [ro_mem_pkg::LINE_BITS-1:0] line_data(input logic [31:0] addr);
      logic [ro_mem_pkg::LINE_BITS-1:0] d;
      logic [31:0]                      base;
      base = {addr[31:6], 6'b000000};  // whole line, whatever the offset
      for (int i = 0; i < ro_mem_pkg::LINE_WORDS; i++) begin
         d[i*32 +: 32] = ref_word(base + 32'(4 * i));
      end
      return d;
   endfunction

   initial begin
      rng     = SEED;
      cycle   = 0;
      arready = 1'b0;
      rvalid  = 1'b0;
      r       = '0;
      forever begin
         @(posedge clk);
         if (!rstn) begin
            addr_q.delete();
            tag_q.delete();
            due_q.delete();
         end else begin
            if (rvalid && rready) begin
               void'(addr_q.pop_front());
               void'(tag_q.pop_front());
               void'(due_q.pop_front());
            end
            if (arvalid && arready) begin
               rng = lcg_step(rng);
               addr_q.push_back(ar.addr);
               tag_q.push_back(ar.tag);
               due_q.push_back(cycle + int'(rng[18:16]));  // 0..7 cycles extra
            end
         end
         cycle++;
         #1;
         rng     = lcg_step(rng);
         arready = (rng[17:16] != 2'b00);
         rvalid  = 1'b0;
         r       = '0;
         if (addr_q.size() > 0) begin
            if (due_q[0] <= cycle) begin  // in order, head only
               rvalid = 1'b1;
               r.tag  = tag_q[0];
               r.data = line_data(addr_q[0]);
            end
         end
      end
   end

endmodule

//--- tests/tb_ro_stage.sv
`timescale 1ns/1ps

module tb_ro_stage;

   localparam int N_THREADS  = 4;
   localparam int LOG_N_TAGS = 3;
   localparam int TIMEOUT    = 5000;

   `include "tb_funcs.svh"

   logic                   clk = 1'b0;
   logic                   rstn;
   logic                   req_valid;
   logic                   req_ready;
   ro_task_pkg::task_req_t req;
   logic                   arvalid;
   logic                   arready;
   ro_mem_pkg::ar_req_t    ar;
   logic                   rvalid;
   logic                   rready;
   ro_mem_pkg::r_beat_t    r;
   logic                   out_valid;
   logic                   out_ready;
   ro_task_pkg::out_beat_t out;
   logic                   idle;

   ro_task_pkg::out_beat_t exp_q [$];
   ro_task_pkg::out_beat_t held_beat;
   logic                   held = 1'b0;
   logic [1:0]             ready_mode = 2'd0;  // 0 always, 1 random, 2 held low
   logic [31:0]            stim_state;
   logic [31:0]            ready_state;
   string                  test_name = "reset";

   ro_stage_top #(.N_THREADS(N_THREADS), .LOG_N_TAGS(LOG_N_TAGS)) i_ro_stage_top (
      .clk       (clk),
      .rstn      (rstn),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .arvalid   (arvalid),
      .arready   (arready),
      .ar        (ar),
      .rvalid    (rvalid),
      .rready    (rready),
      .r         (r),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out       (out),
      .idle      (idle)
   );

   tb_mem_model #(.SEED(32'd88)) i_mem_model (
      .clk     (clk),
      .rstn    (rstn),
      .arvalid (arvalid),
      .arready (arready),
      .ar      (ar),
      .rvalid  (rvalid),
      .rready  (rready),
      .r       (r)
   );

   always #10 clk = ~clk;

   task automatic fail_run();
      $display("TESTS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_value(input string what, input string exp_s, input string act_s);
      $display("error: test %s, %s: expected %s, actual %s", test_name, what, exp_s, act_s);
      fail_run();
   endtask

   task automatic abort_run(input string what);
      $display("test %s failed: %s", test_name, what);
      fail_run();
   endtask

   // expected beats of one task, in word order
   function automatic void push_expected(input ro_task_pkg::task_req_t t);
      ro_task_pkg::out_beat_t b;
      for (int k = 0; k < int'(t.len); k++) begin
         b.tsk  = t.tsk;
         b.data = ref_word(t.addr + 32'(4 * k));
         b.idx  = 5'(k);
         b.last = (k == int'(t.len) - 1);
         exp_q.push_back(b);
      end
   endfunction

   task automatic random_task(output ro_task_pkg::task_req_t t, input int max_len);
      stim_state = lcg_step(stim_state);
      t.tsk      = stim_state;
      stim_state = lcg_step(stim_state);
      t.addr     = {12'h000, stim_state[23:6], 2'b00};
      stim_state = lcg_step(stim_state);
      t.len      = 6'(int'(stim_state[20:16]) % max_len + 1);
   endtask

   // returns 1 ns after the handshake edge of the request already presented
   task automatic wait_accept(input ro_task_pkg::task_req_t t);
      int waited;
      waited = 0;
      @(posedge clk);
      while (!req_ready) begin
         waited++;
         if (waited > TIMEOUT) abort_run("request was never accepted");
         @(posedge clk);
      end
      #1;
      push_expected(t);
      req_valid = 1'b0;
   endtask

   task automatic send_task(input ro_task_pkg::task_req_t t);
      req       = t;
      req_valid = 1'b1;
      wait_accept(t);
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      @(posedge clk);
      while (!idle) begin
         waited++;
         if (waited > TIMEOUT) abort_run("idle did not return high");
         @(posedge clk);
      end
      #1;
      assert (exp_q.size() == 0)
         else report_value("beats left", "0", $sformatf("%0d", exp_q.size()));
   endtask

   initial begin
      ready_state = 32'd88;
      out_ready   = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         case (ready_mode)
            2'd0: out_ready = 1'b1;
            2'd1: begin
               ready_state = lcg_step(ready_state);
               out_ready   = ready_state[16];
            end
            default: out_ready = 1'b0;
         endcase
      end
   end

   // scoreboard and hold check for a stalled beat
   always @(posedge clk) begin
      ro_task_pkg::out_beat_t expected;
      if (rstn) begin
         if (held) begin
            assert (out_valid) else abort_run("out_valid dropped before its beat was taken");
            assert (out == held_beat)
               else report_value("stalled beat", $sformatf("%h", held_beat), $sformatf("%h", out));
         end
         held = 1'b0;
         if (out_valid && out_ready) begin
            assert (exp_q.size() > 0) else abort_run("an output beat came with none expected");
            expected = exp_q.pop_front();
            assert (out == expected)
               else report_value("beat", $sformatf("%h", expected), $sformatf("%h", out));
         end else if (out_valid) begin
            held      = 1'b1;
            held_beat = out;
         end
      end
   end

   initial begin
      ro_task_pkg::task_req_t t;
      int                     accepted;
      stim_state = 32'd88;
      rstn       = 1'b0;
      req_valid  = 1'b0;
      req        = '0;
      repeat (3) @(posedge clk);
      #1;
      rstn = 1'b1;
      assert (idle && req_ready && rready) else abort_run("idle, req_ready or rready low");
      assert (!arvalid && !out_valid) else abort_run("arvalid or out_valid high after reset");

      test_name = "single_word";
      t = '{tsk: 32'h0000_1001, addr: 32'h0000_0100, len: 6'd1};
      send_task(t);
      wait_drained();

      test_name = "line_cross";
      t = '{tsk: 32'h0000_2002, addr: 32'h0000_0f28, len: 6'd20};  // 6 words then 14
      send_task(t);
      wait_drained();

      test_name = "random_back_to_back";
      for (int i = 0; i < 60; i++) begin
         random_task(t, 32);
         send_task(t);
      end
      wait_drained();

      test_name = "random_out_ready";
      ready_mode = 2'd1;
      for (int i = 0; i < 20; i++) begin
         random_task(t, 32);
         send_task(t);
      end
      wait_drained();

      test_name = "thread_limit";
      ready_mode = 2'd2;
      repeat (2) @(posedge clk);
      #1;
      accepted = 0;
      random_task(t, 8);  // short tasks so tags never run out
      req       = t;
      req_valid = 1'b1;
      for (int c = 0; c < 100; c++) begin
         @(posedge clk);
         if (accepted > 0) assert (!idle) else report_value("idle", "0", "1");
         if (req_ready) begin
            accepted++;
            #1;
            push_expected(t);
            random_task(t, 8);
            req = t;
         end else begin
            #1;
         end
      end
      assert (accepted == N_THREADS)
         else report_value("accepted tasks", $sformatf("%0d", N_THREADS),
                           $sformatf("%0d", accepted));
      ready_mode = 2'd0;
      wait_accept(t);
      wait_drained();

      // handshakes back at their reset levels once everything has drained
      assert (req_ready && rready && !arvalid && !out_valid)
         else abort_run("handshake outputs not back at their reset levels after draining");

      $display("TESTS PASSED");
      $finish;
   end

endmodule

//--- compile.f
+incdir+tests
src/ro_mem_pkg.sv
src/ro_task_pkg.sv
src/free_list.sv
src/req_intake.sv
src/line_splitter.sv
src/mshr_table.sv
src/word_unpacker.sv
src/ro_stage_top.sv
tests/tb_mem_model.sv
tests/tb_ro_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_ro_stage -o sim_ro_stage

# the simulator exit code is not used, the log decides
./obj_dir/sim_ro_stage | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
   echo "simulation passed"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi
